// ==== hdl/rv_issue_pkg.sv ====
/*
 * Shared definitions for the decode and issue stage
 * Micro-op and immediate format enums, major opcodes, widths
 */

package rv_issue_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // Integer data path
  localparam int XLEN = 32;

  // Architectural register index, x0..x31
  localparam int REG_ADDR_W = 5;

  // --------------------------------------------------
  // Major opcodes, inst[6:0]
  // --------------------------------------------------

  // R-type register-register ops, ADD SUB MUL
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // I-type register-immediate ops, ADDI
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // U-type load upper immediate
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // --------------------------------------------------
  // Decoded types
  // --------------------------------------------------

  // Micro-op carried to the execute lanes
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_ADDI,
    UOP_LUI,
    UOP_MUL
  } rv_uop;

  // Immediate layout picked by the decoder
  typedef enum logic {
    IMM_I,
    IMM_U
  } rv_imm_type;

endpackage

// ==== hdl/inst_decoder.sv ====
/*
 * Instruction decoder for ADD, SUB, ADDI, LUI, MUL
 * Pure combinational, flags unsupported encodings with val low
 */

module inst_decoder
  import rv_issue_pkg::*;
(
  input  logic [31:0]           inst,
  output logic                  val,
  output rv_uop                 uop,
  output logic [REG_ADDR_W-1:0] raddr0,
  output logic [REG_ADDR_W-1:0] raddr1,
  output logic [REG_ADDR_W-1:0] waddr,
  output logic                  wen,
  output rv_imm_type            imm_sel,
  output logic                  op2_sel
);

  // funct7 patterns within OPC_OP
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    // Defaults describe an R-type op with both sources read
    val     = 1'b0;
    uop     = UOP_ADD;
    raddr0  = inst[19:15];
    raddr1  = inst[24:20];
    waddr   = inst[11:7];
    imm_sel = IMM_I;
    op2_sel = 1'b0;

    case (opcode)
      OPC_OP: begin
        // Only funct3 000 is in the subset
        if (funct3 == 3'b000) begin
          case (funct7)
            F7_BASE: begin
              val = 1'b1;
              uop = UOP_ADD;
            end
            F7_SUB: begin
              val = 1'b1;
              uop = UOP_SUB;
            end
            F7_MUL: begin
              val = 1'b1;
              uop = UOP_MUL;
            end
            default: val = 1'b0;
          endcase
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          val     = 1'b1;
          uop     = UOP_ADDI;
          // rs2 field is immediate bits here, no false hazard
          raddr1  = '0;
          op2_sel = 1'b1;
        end
      end
      OPC_LUI: begin
        val     = 1'b1;
        uop     = UOP_LUI;
        // Operand 1 reads x0, giving zero
        raddr0  = '0;
        raddr1  = '0;
        imm_sel = IMM_U;
        op2_sel = 1'b1;
      end
      default: val = 1'b0;
    endcase

    // x0 destination writes nothing and never goes pending
    wen = val && (waddr != '0);
  end

endmodule

// ==== hdl/imm_gen.sv ====
/*
 * Immediate generator
 * I format sign-extended, U format in the upper 20 bits
 */

module imm_gen
  import rv_issue_pkg::*;
(
  input  logic [31:0] inst,
  input  rv_imm_type  imm_sel,
  output logic [XLEN-1:0] imm
);

  // Both candidate layouts
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;

  // Bits 31:20, sign taken from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};

  // Bits 31:12 with low 12 bits zero
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    case (imm_sel)
      IMM_U:   imm = imm_u;
      default: imm = imm_i;
    endcase
  end

endmodule

// ==== hdl/regfile_pending.sv ====
/*
 * Integer register file with pending bits
 * Two combinational read ports, one write port
 * One pending bit per register, x0 hardwired
 */

module regfile_pending
  import rv_issue_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Read ports
  input  logic [REG_ADDR_W-1:0] raddr0,
  input  logic [REG_ADDR_W-1:0] raddr1,
  output logic [XLEN-1:0]       rdata0,
  output logic [XLEN-1:0]       rdata1,

  // Write port from completion
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]       wdata,
  input  logic                  wen,

  // Pending set on issue, lookups for hazard check
  input  logic [REG_ADDR_W-1:0] pend_set_addr,
  input  logic                  pend_set,
  output logic                  pend0,
  output logic                  pend1,
  output logic                  pend_w,
  input  logic [REG_ADDR_W-1:0] pend_chk_addr
);

  localparam int NREGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0]  regs [NREGS];
  logic [NREGS-1:0] pend;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write clears, a same-cycle set comes last and wins
  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
    end else begin
      if (wen && waddr != '0) begin
        pend[waddr] <= 1'b0;
      end
      if (pend_set && pend_set_addr != '0) begin
        pend[pend_set_addr] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Lookups
  // --------------------------------------------------

  // x0 reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // pend[0] stays clear, so x0 lookups are never pending
  assign pend0  = pend[raddr0];
  assign pend1  = pend[raddr1];
  assign pend_w = pend[pend_chk_addr];

endmodule

// ==== hdl/inst_router.sv ====
/*
 * Lane router
 * MUL goes to the multiply lane, all else to the ALU lane
 */

module inst_router
  import rv_issue_pkg::*;
(
  input  rv_uop uop,
  input  logic  val,
  input  logic  alu_rdy,
  input  logic  mul_rdy,
  output logic  alu_val,
  output logic  mul_val,
  output logic  xfer
);

  logic is_mul;

  assign is_mul = (uop == UOP_MUL);

  // Only the chosen lane sees val
  assign alu_val = val && !is_mul;
  assign mul_val = val && is_mul;

  // Handshake of whichever lane was picked
  assign xfer = (alu_val && alu_rdy) || (mul_val && mul_rdy);

endmodule

// ==== hdl/decode_issue_unit.sv ====
/*
 * In-order single-issue decode stage
 * Fetch register, decode, operand read, RAW/WAW stall
 * Issue to the ALU or multiply lane
 */

module decode_issue_unit
  import rv_issue_pkg::*;
#(
  parameter int SEQ_W = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  // Fetch port
  input  logic                  f_val,
  input  logic [31:0]           f_inst,
  input  logic [XLEN-1:0]       f_pc,
  input  logic [SEQ_W-1:0]      f_seq_num,
  output logic                  f_rdy,

  // Lane handshakes
  output logic                  alu_val,
  output logic                  mul_val,
  input  logic                  alu_rdy,
  input  logic                  mul_rdy,

  // Shared issue payload
  output logic [XLEN-1:0]       x_pc,
  output logic [XLEN-1:0]       x_op1,
  output logic [XLEN-1:0]       x_op2,
  output rv_uop                 x_uop,
  output logic [REG_ADDR_W-1:0] x_waddr,
  output logic                  x_wen,
  output logic [SEQ_W-1:0]      x_seq_num,

  // Completion
  input  logic                  c_val,
  input  logic                  c_wen,
  input  logic [REG_ADDR_W-1:0] c_waddr,
  input  logic [XLEN-1:0]       c_wdata
);

  // --------------------------------------------------
  // Fetch register
  // --------------------------------------------------

  logic             fr_val;
  logic [31:0]      fr_inst;
  logic [XLEN-1:0]  fr_pc;
  logic [SEQ_W-1:0] fr_seq;
  logic             f_xfer;
  logic             x_xfer;

  assign f_xfer = f_val && f_rdy;

  // Empty slot, or the held one leaves this cycle
  assign f_rdy = !fr_val || x_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      fr_val <= 1'b0;
    end else if (f_xfer) begin
      fr_val <= 1'b1;
    end else if (x_xfer) begin
      fr_val <= 1'b0;
    end
  end

  // Payload only loads on accept, held through stalls
  always_ff @(posedge clk) begin
    if (f_xfer) begin
      fr_inst <= f_inst;
      fr_pc   <= f_pc;
      fr_seq  <= f_seq_num;
    end
  end

  // --------------------------------------------------
  // Decode, immediate, register read
  // --------------------------------------------------

  logic                  dec_val;
  rv_uop                 dec_uop;
  logic [REG_ADDR_W-1:0] dec_raddr0;
  logic [REG_ADDR_W-1:0] dec_raddr1;
  logic [REG_ADDR_W-1:0] dec_waddr;
  logic                  dec_wen;
  rv_imm_type            dec_imm_sel;
  logic                  dec_op2_sel;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rdata0;
  logic [XLEN-1:0]       rdata1;
  logic                  pend0;
  logic                  pend1;
  logic                  pend_w;
  logic                  stall_pend;

  inst_decoder u_decoder (
    .inst    (fr_inst),
    .val     (dec_val),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_sel (dec_imm_sel),
    .op2_sel (dec_op2_sel)
  );

  imm_gen u_imm_gen (
    .inst    (fr_inst),
    .imm_sel (dec_imm_sel),
    .imm     (imm)
  );

  // Pending bit set on the issue edge, cleared by completion
  regfile_pending u_regfile (
    .clk           (clk),
    .rst           (rst),
    .raddr0        (dec_raddr0),
    .raddr1        (dec_raddr1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .waddr         (c_waddr),
    .wdata         (c_wdata),
    .wen           (c_val && c_wen),
    .pend_set_addr (dec_waddr),
    .pend_set      (dec_wen && x_xfer),
    .pend0         (pend0),
    .pend1         (pend1),
    .pend_w        (pend_w),
    .pend_chk_addr (dec_waddr)
  );

  // RAW on either source, WAW on the destination
  assign stall_pend = pend0 || pend1 || pend_w;

  // --------------------------------------------------
  // Routing and payload
  // --------------------------------------------------

  // Lane not ready stalls through the router handshake
  inst_router u_router (
    .uop     (dec_uop),
    .val     (fr_val && dec_val && !stall_pend),
    .alu_rdy (alu_rdy),
    .mul_rdy (mul_rdy),
    .alu_val (alu_val),
    .mul_val (mul_val),
    .xfer    (x_xfer)
  );

  assign x_pc      = fr_pc;
  assign x_op1     = rdata0;
  assign x_op2     = dec_op2_sel ? imm : rdata1;
  assign x_uop     = dec_uop;
  assign x_waddr   = dec_waddr;
  assign x_wen     = dec_wen;
  assign x_seq_num = fr_seq;

endmodule

// ==== hdl/exec_lanes.sv ====
/*
 * Execute lanes and completion port
 * One-cycle ALU lane, three-stage multiply lane
 */

module exec_lanes
  import rv_issue_pkg::*;
#(
  parameter int SEQ_W = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  // Lane handshakes
  input  logic                  alu_val,
  input  logic                  mul_val,
  output logic                  alu_rdy,
  output logic                  mul_rdy,

  // Issue payload
  input  logic [XLEN-1:0]       x_pc,
  input  logic [XLEN-1:0]       x_op1,
  input  logic [XLEN-1:0]       x_op2,
  input  rv_uop                 x_uop,
  input  logic [REG_ADDR_W-1:0] x_waddr,
  input  logic                  x_wen,
  input  logic [SEQ_W-1:0]      x_seq_num,

  // Completion port
  output logic                  c_val,
  output logic                  c_wen,
  output logic [REG_ADDR_W-1:0] c_waddr,
  output logic [XLEN-1:0]       c_wdata,
  output logic [SEQ_W-1:0]      c_seq_num
);

  localparam int MUL_STAGES = 3;

  // --------------------------------------------------
  // ALU lane
  // --------------------------------------------------

  logic                  alu_fire;
  logic [XLEN-1:0]       alu_res;
  logic                  a_val;
  logic                  a_wen;
  logic [REG_ADDR_W-1:0] a_waddr;
  logic [XLEN-1:0]       a_data;
  logic [SEQ_W-1:0]      a_seq;

  assign alu_fire = alu_val && alu_rdy;

  // LUI passes the immediate straight through
  always_comb begin
    case (x_uop)
      UOP_SUB: alu_res = x_op1 - x_op2;
      UOP_LUI: alu_res = x_op2;
      default: alu_res = x_op1 + x_op2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_val <= 1'b0;
    end else begin
      a_val <= alu_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_fire) begin
      a_wen   <= x_wen;
      a_waddr <= x_waddr;
      a_data  <= alu_res;
      a_seq   <= x_seq_num;
    end
  end

  // --------------------------------------------------
  // Multiply lane
  // --------------------------------------------------

  logic                  mul_fire;
  logic [MUL_STAGES-1:0] m_val;
  logic                  m_wen   [MUL_STAGES];
  logic [REG_ADDR_W-1:0] m_waddr [MUL_STAGES];
  logic [XLEN-1:0]       m_prod  [MUL_STAGES];
  logic [SEQ_W-1:0]      m_seq   [MUL_STAGES];

  // Fully pipelined, one new multiply per cycle
  assign mul_rdy  = 1'b1;
  assign mul_fire = mul_val && mul_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_val <= '0;
    end else begin
      m_val <= {m_val[MUL_STAGES-2:0], mul_fire};
    end
  end

  // Low 32 bits of the product formed in stage 1
  always_ff @(posedge clk) begin
    m_wen[0]   <= x_wen;
    m_waddr[0] <= x_waddr;
    m_prod[0]  <= x_op1 * x_op2;
    m_seq[0]   <= x_seq_num;
    for (int i = 1; i < MUL_STAGES; i++) begin
      m_wen[i]   <= m_wen[i-1];
      m_waddr[i] <= m_waddr[i-1];
      m_prod[i]  <= m_prod[i-1];
      m_seq[i]   <= m_seq[i-1];
    end
  end

  // --------------------------------------------------
  // Completion
  // --------------------------------------------------

  // ALU result would land with stage 3, so hold ALU off
  assign alu_rdy = !m_val[1];

  // At most one lane is valid here
  assign c_val     = a_val || m_val[MUL_STAGES-1];
  assign c_wen     = a_val ? a_wen   : m_wen[MUL_STAGES-1];
  assign c_waddr   = a_val ? a_waddr : m_waddr[MUL_STAGES-1];
  assign c_wdata   = a_val ? a_data  : m_prod[MUL_STAGES-1];
  assign c_seq_num = a_val ? a_seq   : m_seq[MUL_STAGES-1];

endmodule

// ==== hdl/issue_top.sv ====
/*
 * Top level of the decode and issue stage
 * Decode-issue unit wired to the execute lanes
 */

module issue_top
  import rv_issue_pkg::*;
#(
  parameter int SEQ_W = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  // Fetch port
  input  logic                  f_val,
  input  logic [31:0]           f_inst,
  input  logic [XLEN-1:0]       f_pc,
  input  logic [SEQ_W-1:0]      f_seq_num,
  output logic                  f_rdy,

  // Completion port
  output logic                  c_val,
  output logic                  c_wen,
  output logic [REG_ADDR_W-1:0] c_waddr,
  output logic [XLEN-1:0]       c_wdata,
  output logic [SEQ_W-1:0]      c_seq_num
);

  // Decode to lanes
  logic                  alu_val;
  logic                  mul_val;
  logic                  alu_rdy;
  logic                  mul_rdy;
  logic [XLEN-1:0]       x_pc;
  logic [XLEN-1:0]       x_op1;
  logic [XLEN-1:0]       x_op2;
  rv_uop                 x_uop;
  logic [REG_ADDR_W-1:0] x_waddr;
  logic                  x_wen;
  logic [SEQ_W-1:0]      x_seq_num;

  decode_issue_unit #(
    .SEQ_W (SEQ_W)
  ) u_decode (
    .clk       (clk),
    .rst       (rst),
    .f_val     (f_val),
    .f_inst    (f_inst),
    .f_pc      (f_pc),
    .f_seq_num (f_seq_num),
    .f_rdy     (f_rdy),
    .alu_val   (alu_val),
    .mul_val   (mul_val),
    .alu_rdy   (alu_rdy),
    .mul_rdy   (mul_rdy),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_uop     (x_uop),
    .x_waddr   (x_waddr),
    .x_wen     (x_wen),
    .x_seq_num (x_seq_num),
    .c_val     (c_val),
    .c_wen     (c_wen),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata)
  );

  // Completion also feeds back into the regfile
  exec_lanes #(
    .SEQ_W (SEQ_W)
  ) u_lanes (
    .clk       (clk),
    .rst       (rst),
    .alu_val   (alu_val),
    .mul_val   (mul_val),
    .alu_rdy   (alu_rdy),
    .mul_rdy   (mul_rdy),
    .x_pc      (x_pc),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_uop     (x_uop),
    .x_waddr   (x_waddr),
    .x_wen     (x_wen),
    .x_seq_num (x_seq_num),
    .c_val     (c_val),
    .c_wen     (c_wen),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata),
    .c_seq_num (c_seq_num)
  );

endmodule

// ==== verif/tb_completion_checker.sv ====
/*
 * Completion port checker
 * Golden compare per sequence number, per-register write order
 * One line per finished test, closing count line
 */

module tb_completion_checker #(
  parameter int SEQ_W     = 8,
  parameter int MAX_INSTS = 64,
  parameter int MAX_TESTS = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             c_val,
  input  logic             c_wen,
  input  logic [4:0]       c_waddr,
  input  logic [31:0]      c_wdata,
  input  logic [SEQ_W-1:0] c_seq_num,
  input  logic [4:0]       exp_rd    [MAX_INSTS],
  input  logic [31:0]      exp_val   [MAX_INSTS],
  input  int               inst_test [MAX_INSTS],
  input  logic [31:0]      test_id   [MAX_TESTS],
  input  int               test_len  [MAX_TESTS],
  input  int               n_tests,
  input  int               n_insts,
  output int               pass_cnt,
  output int               fail_cnt,
  output int               err_cnt,
  output logic             all_done
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        done     [MAX_INSTS];
  int          left     [MAX_TESTS];
  logic        bad      [MAX_TESTS];
  int          bad_seq  [MAX_TESTS];
  string       bad_what [MAX_TESTS];
  logic [31:0] bad_exp  [MAX_TESTS];
  logic [31:0] bad_act  [MAX_TESTS];
  // Last sequence number written per register, -1 for none
  int          last_seq [32];
  int          seq;
  int          t;

  function automatic string test_name(input logic [31:0] id);
    case (id)
      32'd1:   return "indep_alu";
      32'd2:   return "lui_addi_raw";
      32'd3:   return "mul_raw";
      32'd4:   return "mul_addi_waw";
      32'd5:   return "x0_dest";
      32'd6:   return "mul_mix";
      default: return "unknown";
    endcase
  endfunction

  // Keeps the first mismatch of a test
  task automatic note_mismatch(input int ti, input int s, input string what,
                               input logic [31:0] expv, input logic [31:0] actv);
    if (!bad[ti]) begin
      bad[ti]      = 1'b1;
      bad_seq[ti]  = s;
      bad_what[ti] = what;
      bad_exp[ti]  = expv;
      bad_act[ti]  = actv;
    end
  endtask

  task automatic report_test(input int ti);
    if (bad[ti]) begin
      $display("FAIL %s: seq %0d %s expected %h actual %h", test_name(test_id[ti]),
               bad_seq[ti], bad_what[ti], bad_exp[ti], bad_act[ti]);
      fail_cnt = fail_cnt + 1;
    end else begin
      $display("PASS %s: %0d instructions", test_name(test_id[ti]), test_len[ti]);
      pass_cnt = pass_cnt + 1;
    end
  endtask

  // --------------------------------------------------
  // Sampled at the edge, outputs settled from the cycle before
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MAX_INSTS; i++) begin
        done[i] = 1'b0;
      end
      for (int i = 0; i < MAX_TESTS; i++) begin
        left[i] = test_len[i];
        bad[i]  = 1'b0;
      end
      for (int i = 0; i < 32; i++) begin
        last_seq[i] = -1;
      end
      pass_cnt = 0;
      fail_cnt = 0;
      err_cnt  = 0;
      all_done = 1'b0;
    end else if (c_val) begin
      seq = int'(c_seq_num);
      if (seq >= n_insts) begin
        $display("ERROR: completion for sequence number %0d, which was never fetched", seq);
        err_cnt = err_cnt + 1;
      end else if (done[seq]) begin
        $display("ERROR: sequence number %0d completed a second time", seq);
        err_cnt = err_cnt + 1;
      end else begin
        done[seq] = 1'b1;
        t = inst_test[seq];
        if (c_wen && c_waddr == 5'd0) begin
          $display("ERROR: sequence number %0d wrote register x0", seq);
          err_cnt = err_cnt + 1;
        end else if (exp_rd[seq] == 5'd0) begin
          // x0 destination, value is dropped
          if (c_wen) begin
            note_mismatch(t, seq, "wen", 32'd0, 32'd1);
          end
        end else if (!c_wen) begin
          note_mismatch(t, seq, "wen", 32'd1, 32'd0);
        end else if (c_waddr != exp_rd[seq]) begin
          note_mismatch(t, seq, "dest", 32'(exp_rd[seq]), 32'(c_waddr));
        end else begin
          if (c_wdata != exp_val[seq]) begin
            note_mismatch(t, seq, "data", exp_val[seq], c_wdata);
          end
          // WAW order on the same register
          if (last_seq[c_waddr] > seq) begin
            $display("ERROR: x%0d written by seq %0d after seq %0d, out of order",
                     c_waddr, seq, last_seq[c_waddr]);
            err_cnt = err_cnt + 1;
          end
          last_seq[c_waddr] = seq;
        end
        left[t] = left[t] - 1;
        if (left[t] == 0) begin
          report_test(t);
          if (pass_cnt + fail_cnt == n_tests) begin
            $display("Summary: %0d tests passed, %0d failed, %0d other errors",
                     pass_cnt, fail_cnt, err_cnt);
            all_done = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== verif/tb_issue_top.sv ====
/*
 * Testbench top for the decode and issue stage
 * Clock, reset, golden file loader, fetch driver with LFSR bubbles
 * Cycle timeout and final verdict
 */

module tb_issue_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEQ_W        = 8;
  localparam int MAX_WORDS    = 512;
  localparam int MAX_INSTS    = 64;
  localparam int MAX_TESTS    = 16;
  localparam int DRAIN_CYCLES = 10;
  localparam logic [31:0] PC_BASE   = 32'h0000_1000;
  localparam logic [15:0] LFSR_SEED = 16'd39;
  // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  // DUT inputs start at known values
  logic             clk       = 1'b0;
  logic             rst       = 1'b1;
  logic             f_val     = 1'b0;
  logic [31:0]      f_inst    = '0;
  logic [31:0]      f_pc      = '0;
  logic [SEQ_W-1:0] f_seq_num = '0;
  logic             f_rdy;
  logic             c_val;
  logic             c_wen;
  logic [4:0]       c_waddr;
  logic [31:0]      c_wdata;
  logic [SEQ_W-1:0] c_seq_num;

  // Golden data as raw words and a per-instruction view
  logic [31:0] golden    [MAX_WORDS];
  logic [31:0] g_inst    [MAX_INSTS];
  logic [4:0]  exp_rd    [MAX_INSTS];
  logic [31:0] exp_val   [MAX_INSTS];
  int          inst_test [MAX_INSTS];
  logic [31:0] test_id   [MAX_TESTS];
  int          test_len  [MAX_TESTS];
  int          n_insts;
  int          n_tests;

  // Checker results
  int   pass_cnt;
  int   fail_cnt;
  int   err_cnt;
  logic all_done;

  // Driver and timeout state
  int          fetch_idx   = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 50;
  logic [15:0] lfsr        = LFSR_SEED;
  logic        bubble;

  // --------------------------------------------------
  // DUT and checker
  // --------------------------------------------------

  issue_top #(
    .SEQ_W (SEQ_W)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .f_val     (f_val),
    .f_inst    (f_inst),
    .f_pc      (f_pc),
    .f_seq_num (f_seq_num),
    .f_rdy     (f_rdy),
    .c_val     (c_val),
    .c_wen     (c_wen),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata),
    .c_seq_num (c_seq_num)
  );

  tb_completion_checker #(
    .SEQ_W     (SEQ_W),
    .MAX_INSTS (MAX_INSTS),
    .MAX_TESTS (MAX_TESTS)
  ) u_checker (
    .clk       (clk),
    .rst       (rst),
    .c_val     (c_val),
    .c_wen     (c_wen),
    .c_waddr   (c_waddr),
    .c_wdata   (c_wdata),
    .c_seq_num (c_seq_num),
    .exp_rd    (exp_rd),
    .exp_val   (exp_val),
    .inst_test (inst_test),
    .test_id   (test_id),
    .test_len  (test_len),
    .n_tests   (n_tests),
    .n_insts   (n_insts),
    .pass_cnt  (pass_cnt),
    .fail_cnt  (fail_cnt),
    .err_cnt   (err_cnt),
    .all_done  (all_done)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // One Galois shift
  // Output bit is state[0] before the shift
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  // Splits the flat word list into tests and instructions
  task automatic load_golden();
    int pos;
    int cnt;
    $readmemh("verif/issue_golden.txt", golden);
    pos     = 0;
    n_tests = 0;
    n_insts = 0;
    // Test id 0 ends the list
    while (pos < MAX_WORDS - 2 && golden[pos] != 32'd0 && n_tests < MAX_TESTS) begin
      test_id[n_tests]  = golden[pos];
      cnt               = golden[pos+1];
      test_len[n_tests] = cnt;
      pos = pos + 2;
      for (int k = 0; k < cnt; k++) begin
        g_inst[n_insts]    = golden[pos];
        exp_rd[n_insts]    = golden[pos+1][4:0];
        exp_val[n_insts]   = golden[pos+2];
        inst_test[n_insts] = n_tests;
        pos     = pos + 3;
        n_insts = n_insts + 1;
      end
      n_tests = n_tests + 1;
    end
    // Room for stalls, multiply latency and bubbles
    cycle_limit = n_insts * 8 + 50;
  endtask

  // --------------------------------------------------
  // Fetch driver
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      f_val <= 1'b0;
      fetch_idx = 0;
    end else begin
      // Move on only after an accepted transfer
      if (f_val && f_rdy) begin
        fetch_idx = fetch_idx + 1;
      end
      if (fetch_idx < n_insts) begin
        bubble = lfsr[0];
        lfsr   = lfsr_step(lfsr);
      end else begin
        bubble = 1'b1;
      end
      if (!bubble) begin
        f_val     <= 1'b1;
        f_inst    <= g_inst[fetch_idx];
        f_pc      <= PC_BASE + 32'(4 * fetch_idx);
        f_seq_num <= SEQ_W'(fetch_idx);
      end else begin
        f_val <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Timeout and verdict
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("Timeout: not all completions seen after %0d cycles", cycle_cnt);
        $display("TEST FAIL");
        $finish;
      end
    end
  end

  initial begin
    load_golden();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait (all_done);
    // Let any stray completion show up
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == n_tests) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/issue_golden.txt ====
// Per test: test_id instruction_count, then per instruction: inst_word dest_reg expected_result
// All hex; registers start at zero and carry over between tests; test_id 0 ends the list
// indep_alu: ADDI with negative immediates, ADD, SUB
00000001 00000006
06400093 00000001 00000064
FF900113 00000002 FFFFFFF9
80000193 00000003 FFFFF800
00208233 00000004 0000005D
403082B3 00000005 00000864
FFF10313 00000006 FFFFFFF8
// lui_addi_raw: LUI then ADDI on the same register
00000002 00000004
123453B7 00000007 12345000
67838393 00000007 12345678
DEADC437 00000008 DEADC000
EEF40413 00000008 DEADBEEF
// mul_raw: MUL result feeds ADD and SUB
00000003 00000004
022084B3 00000009 FFFFFD44
00548533 0000000A 000005A8
023385B3 0000000B 5D4C4000
40A58633 0000000C 5D4C3A58
// mul_addi_waw: MUL and ADDI to x13, then a read of x13
00000004 00000003
026206B3 0000000D FFFFFD18
00500693 0000000D 00000005
00D68733 0000000E 0000000A
// x0_dest: writes to x0 are dropped, x0 reads zero
00000005 00000004
03708013 00000000 00000000
00520033 00000000 00000000
001007B3 0000000F 00000064
40100833 00000010 FFFFFF9C
// mul_mix: back-to-back MULs with an ALU op between
00000006 00000004
021088B3 00000011 00002710
02210933 00000012 00000031
00118993 00000013 FFFFF801
01288A33 00000014 00002741
00000000

// ==== filelist.f ====
hdl/rv_issue_pkg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/regfile_pending.sv
hdl/inst_router.sv
hdl/decode_issue_unit.sv
hdl/exec_lanes.sv
hdl/issue_top.sv
verif/tb_completion_checker.sv
verif/tb_issue_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_issue
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_issue_top \
  -f filelist.f -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
